/* hdl/axil_ram_pkg.sv */
// AXI4-Lite dual-port RAM package
// Sizes, AXI channel payload structs and the memory command struct

`default_nettype none

package axil_ram_pkg;

    // Bus and memory sizes
    localparam int axil_data_w     = 32;
    localparam int axil_addr_w     = 12;
    localparam int axil_strb_w     = axil_data_w / 8;
    localparam int ram_word_addr_w = 10;
    localparam int ram_depth       = 2 ** ram_word_addr_w;

    localparam logic [1:0] axil_resp_okay = 2'b00;

    // Address channel, shared by aw and ar
    typedef struct packed {
        logic [axil_addr_w-1:0] addr;
        logic [2:0]             prot;
    } axil_aw_t;

    typedef struct packed {
        logic [axil_data_w-1:0] data;
        logic [axil_strb_w-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [axil_data_w-1:0] data;
        logic [1:0]             resp;
    } axil_r_t;

    // One port's request to the shared memory, wr_en and rd_en exclusive
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [ram_word_addr_w-1:0] wr_addr;
        logic [ram_word_addr_w-1:0] rd_addr;
        logic [axil_data_w-1:0]     wr_data;
        logic [axil_strb_w-1:0]     wr_strb;
    } ram_cmd_t;

endpackage

`default_nettype wire

/* hdl/dp_byte_ram.sv */
// Two-port word memory with byte write enables
// Each port has a registered read word, updated only on its rd_en

`default_nettype none

module dp_byte_ram (
    input  logic                                a_clk,
    input  axil_ram_pkg::ram_cmd_t              cmd_a,
    input  axil_ram_pkg::ram_cmd_t              cmd_b,
    output logic [axil_ram_pkg::axil_data_w-1:0] rd_word_a,
    output logic [axil_ram_pkg::axil_data_w-1:0] rd_word_b
);

    import axil_ram_pkg::*;

    localparam int byte_w = axil_data_w / axil_strb_w;

    // Storage starts out cleared
    logic [axil_data_w-1:0] mem [ram_depth] = '{default: '0};

    // Both write ports share one process; same-word collisions are undefined
    always_ff @(posedge a_clk) begin
        for (int i = 0; i < axil_strb_w; i++) begin
            if (cmd_a.wr_en && cmd_a.wr_strb[i]) begin
                mem[cmd_a.wr_addr][byte_w*i +: byte_w] <= cmd_a.wr_data[byte_w*i +: byte_w];
            end
            if (cmd_b.wr_en && cmd_b.wr_strb[i]) begin
                mem[cmd_b.wr_addr][byte_w*i +: byte_w] <= cmd_b.wr_data[byte_w*i +: byte_w];
            end
        end
    end

    // Read words hold their value until the next read on that port
    always_ff @(posedge a_clk) begin
        if (cmd_a.rd_en) begin
            rd_word_a <= mem[cmd_a.rd_addr];
        end
    end

    always_ff @(posedge a_clk) begin
        if (cmd_b.rd_en) begin
            rd_word_b <= mem[cmd_b.rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/axil_port_ctrl.sv */
// AXI4-Lite port controller for one side of the dual-port RAM
// Accepts one write or one read per turn and alternates when both wait

`default_nettype none

module axil_port_ctrl (
    input  logic                   a_clk,
    input  logic                   a_rst,

    // Write address and data
    input  axil_ram_pkg::axil_aw_t aw,
    input  logic                   awvalid,
    output logic                   awready,
    input  axil_ram_pkg::axil_w_t  w,
    input  logic                   wvalid,
    output logic                   wready,

    // Write response
    output axil_ram_pkg::axil_b_t  b,
    output logic                   bvalid,
    input  logic                   bready,

    // Read address
    input  axil_ram_pkg::axil_aw_t ar,
    input  logic                   arvalid,
    output logic                   arready,

    // Handoff to the read output stage
    input  logic                   pipe_free,
    output logic                   rvalid_int,

    // Memory command
    output axil_ram_pkg::ram_cmd_t cmd
);

    import axil_ram_pkg::*;

    // Byte address bits dropped to form the word index
    localparam int word_lsb = axil_addr_w - ram_word_addr_w;

    logic wr_eligible;
    logic rd_eligible;
    logic do_wr;
    logic do_rd;

    // High when the most recent accepted operation was a write
    logic last_wr;

    logic [ram_word_addr_w-1:0] wr_word_addr;
    logic [ram_word_addr_w-1:0] rd_word_addr;

    assign wr_word_addr = aw.addr[axil_addr_w-1:word_lsb];
    assign rd_word_addr = ar.addr[axil_addr_w-1:word_lsb];

    // Eligibility and turn selection
    always_comb begin
        // Need both aw and w, a free b slot, and no acceptance pulse in progress
        wr_eligible = awvalid && wvalid
                   && (!bvalid || bready)
                   && !awready && !wready;

        // A read needs room in the controller slot or an advancing pipe
        rd_eligible = arvalid && !arready
                   && (!rvalid_int || pipe_free);

        // Write wins a tie unless it also had the previous turn
        do_wr = wr_eligible && (!rd_eligible || !last_wr);
        do_rd = rd_eligible && !do_wr;
    end

    // Memory command follows the turn decision in the same cycle
    always_comb begin
        cmd.wr_en   = do_wr;
        cmd.rd_en   = do_rd;
        cmd.wr_addr = wr_word_addr;
        cmd.rd_addr = rd_word_addr;
        cmd.wr_data = w.data;
        cmd.wr_strb = w.strb;
    end

    // Handshake flags
    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            bvalid     <= 1'b0;
            rvalid_int <= 1'b0;
            last_wr    <= 1'b1;
        end else begin
            // Ready pulses last exactly one cycle
            awready <= do_wr;
            wready  <= do_wr;
            arready <= do_rd;

            // Response held until the master takes it
            bvalid <= do_wr || (bvalid && !bready);

            // Item leaves when the pipe takes it, a new read refills it
            rvalid_int <= do_rd || (rvalid_int && !pipe_free);

            if (do_wr) begin
                last_wr <= 1'b1;
            end else if (do_rd) begin
                last_wr <= 1'b0;
            end
        end
    end

    // No error cases, so every write completes OKAY
    assign b.resp = axil_resp_okay;

endmodule

`default_nettype wire

/* hdl/axil_rdata_pipe.sv */
// Read-response output register with back-pressure
// Holds one item and advances when empty or when the master takes it

`default_nettype none

module axil_rdata_pipe (
    input  logic                                 a_clk,
    input  logic                                 a_rst,
    input  logic                                 in_valid,
    input  logic [axil_ram_pkg::axil_data_w-1:0] in_data,
    output logic                                 pipe_free,
    input  logic                                 rready,
    output logic                                 rvalid,
    output axil_ram_pkg::axil_r_t                r
);

    import axil_ram_pkg::*;

    logic [axil_data_w-1:0] data_q;

    // Register can load this cycle
    assign pipe_free = !rvalid || rready;

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            rvalid <= 1'b0;
        end else if (pipe_free) begin
            rvalid <= in_valid;
        end
    end

    always_ff @(posedge a_clk) begin
        if (pipe_free) begin
            data_q <= in_data;
        end
    end

    assign r.data = data_q;
    assign r.resp = axil_resp_okay;

endmodule

`default_nettype wire

/* hdl/axil_dp_ram.sv */
// AXI4-Lite dual-port RAM top level
// Two independent slave ports share one byte-strobed word memory

`default_nettype none

module axil_dp_ram (
    input  logic                   a_clk,
    input  logic                   a_rst,

    // Port a
    input  axil_ram_pkg::axil_aw_t s_axil_a_aw,
    input  axil_ram_pkg::axil_aw_t s_axil_a_ar,
    input  axil_ram_pkg::axil_w_t  s_axil_a_w,
    input  logic                   s_axil_a_awvalid,
    input  logic                   s_axil_a_wvalid,
    input  logic                   s_axil_a_arvalid,
    input  logic                   s_axil_a_bready,
    input  logic                   s_axil_a_rready,
    output logic                   s_axil_a_awready,
    output logic                   s_axil_a_wready,
    output logic                   s_axil_a_arready,
    output logic                   s_axil_a_bvalid,
    output logic                   s_axil_a_rvalid,
    output axil_ram_pkg::axil_b_t  s_axil_a_b,
    output axil_ram_pkg::axil_r_t  s_axil_a_r,

    // Port b
    input  axil_ram_pkg::axil_aw_t s_axil_b_aw,
    input  axil_ram_pkg::axil_aw_t s_axil_b_ar,
    input  axil_ram_pkg::axil_w_t  s_axil_b_w,
    input  logic                   s_axil_b_awvalid,
    input  logic                   s_axil_b_wvalid,
    input  logic                   s_axil_b_arvalid,
    input  logic                   s_axil_b_bready,
    input  logic                   s_axil_b_rready,
    output logic                   s_axil_b_awready,
    output logic                   s_axil_b_wready,
    output logic                   s_axil_b_arready,
    output logic                   s_axil_b_bvalid,
    output logic                   s_axil_b_rvalid,
    output axil_ram_pkg::axil_b_t  s_axil_b_b,
    output axil_ram_pkg::axil_r_t  s_axil_b_r
);

    import axil_ram_pkg::*;

    ram_cmd_t               cmd_a;
    ram_cmd_t               cmd_b;
    logic [axil_data_w-1:0] rd_word_a;
    logic [axil_data_w-1:0] rd_word_b;
    logic                   rvalid_int_a;
    logic                   rvalid_int_b;
    logic                   pipe_free_a;
    logic                   pipe_free_b;

    axil_port_ctrl u_ctrl_a (
        .a_clk      (a_clk),
        .a_rst      (a_rst),
        .aw         (s_axil_a_aw),
        .awvalid    (s_axil_a_awvalid),
        .awready    (s_axil_a_awready),
        .w          (s_axil_a_w),
        .wvalid     (s_axil_a_wvalid),
        .wready     (s_axil_a_wready),
        .b          (s_axil_a_b),
        .bvalid     (s_axil_a_bvalid),
        .bready     (s_axil_a_bready),
        .ar         (s_axil_a_ar),
        .arvalid    (s_axil_a_arvalid),
        .arready    (s_axil_a_arready),
        .pipe_free  (pipe_free_a),
        .rvalid_int (rvalid_int_a),
        .cmd        (cmd_a)
    );

    axil_port_ctrl u_ctrl_b (
        .a_clk      (a_clk),
        .a_rst      (a_rst),
        .aw         (s_axil_b_aw),
        .awvalid    (s_axil_b_awvalid),
        .awready    (s_axil_b_awready),
        .w          (s_axil_b_w),
        .wvalid     (s_axil_b_wvalid),
        .wready     (s_axil_b_wready),
        .b          (s_axil_b_b),
        .bvalid     (s_axil_b_bvalid),
        .bready     (s_axil_b_bready),
        .ar         (s_axil_b_ar),
        .arvalid    (s_axil_b_arvalid),
        .arready    (s_axil_b_arready),
        .pipe_free  (pipe_free_b),
        .rvalid_int (rvalid_int_b),
        .cmd        (cmd_b)
    );

    // Read data leaves through one register stage per port
    axil_rdata_pipe u_pipe_a (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .in_valid  (rvalid_int_a),
        .in_data   (rd_word_a),
        .pipe_free (pipe_free_a),
        .rready    (s_axil_a_rready),
        .rvalid    (s_axil_a_rvalid),
        .r         (s_axil_a_r)
    );

    axil_rdata_pipe u_pipe_b (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .in_valid  (rvalid_int_b),
        .in_data   (rd_word_b),
        .pipe_free (pipe_free_b),
        .rready    (s_axil_b_rready),
        .rvalid    (s_axil_b_rvalid),
        .r         (s_axil_b_r)
    );

    dp_byte_ram u_ram (
        .a_clk     (a_clk),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .rd_word_a (rd_word_a),
        .rd_word_b (rd_word_b)
    );

endmodule

`default_nettype wire

/* test/tb_axil_dp_ram.sv */
// Testbench for the AXI4-Lite dual-port RAM
// Random masters on both ports, checked against a word-array model

`default_nettype none

module tb_axil_dp_ram;

    timeunit 1ns;
    timeprecision 1ps;

    import axil_ram_pkg::*;

    localparam int n_txn       = 16;
    localparam int n_mixed     = 24;
    localparam int half_words  = ram_depth / 2;
    // Reset reads, full writes, partial writes, concurrent plus cross reads, mixed traffic
    localparam int total_txn   = 2 * 8 + 2 * (2 * n_txn) + 2 * (2 * n_txn)
                               + 2 * (3 * n_txn) + 2 * (2 * n_mixed);
    localparam int cycle_limit = 40 * total_txn;

    logic     a_clk;
    logic     a_rst;
    axil_aw_t aw [2];
    axil_aw_t ar [2];
    axil_w_t  w [2];
    logic     awvalid [2];
    logic     wvalid [2];
    logic     arvalid [2];
    logic     bready [2];
    logic     rready [2];
    logic     awready [2];
    logic     wready [2];
    logic     arready [2];
    logic     bvalid [2];
    logic     rvalid [2];
    axil_b_t  b [2];
    axil_r_t  r [2];

    logic [axil_data_w-1:0] model [ram_depth];

    int    errors;
    int    passes;
    int    fails;
    int    cycles;
    int    rd_out [2];
    int    wr_out [2];
    string test_name;

    axil_dp_ram uut (
        .a_clk            (a_clk),
        .a_rst            (a_rst),
        .s_axil_a_aw      (aw[0]),
        .s_axil_a_ar      (ar[0]),
        .s_axil_a_w       (w[0]),
        .s_axil_a_awvalid (awvalid[0]),
        .s_axil_a_wvalid  (wvalid[0]),
        .s_axil_a_arvalid (arvalid[0]),
        .s_axil_a_bready  (bready[0]),
        .s_axil_a_rready  (rready[0]),
        .s_axil_a_awready (awready[0]),
        .s_axil_a_wready  (wready[0]),
        .s_axil_a_arready (arready[0]),
        .s_axil_a_bvalid  (bvalid[0]),
        .s_axil_a_rvalid  (rvalid[0]),
        .s_axil_a_b       (b[0]),
        .s_axil_a_r       (r[0]),
        .s_axil_b_aw      (aw[1]),
        .s_axil_b_ar      (ar[1]),
        .s_axil_b_w       (w[1]),
        .s_axil_b_awvalid (awvalid[1]),
        .s_axil_b_wvalid  (wvalid[1]),
        .s_axil_b_arvalid (arvalid[1]),
        .s_axil_b_bready  (bready[1]),
        .s_axil_b_rready  (rready[1]),
        .s_axil_b_awready (awready[1]),
        .s_axil_b_wready  (wready[1]),
        .s_axil_b_arready (arready[1]),
        .s_axil_b_bvalid  (bvalid[1]),
        .s_axil_b_rvalid  (rvalid[1]),
        .s_axil_b_b       (b[1]),
        .s_axil_b_r       (r[1])
    );

    initial begin
        a_clk = 1'b0;
        forever #4 a_clk = ~a_clk;
    end

    // Watchdog
    always @(posedge a_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // Track outstanding responses to catch lost, duplicated or excess items
    always @(posedge a_clk) begin
        if (!a_rst) begin
            for (int p = 0; p < 2; p++) begin
                if (awvalid[p] && awready[p]) wr_out[p]++;
                if (bvalid[p] && bready[p]) wr_out[p]--;
                if (arvalid[p] && arready[p]) rd_out[p]++;
                if (rvalid[p] && rready[p]) rd_out[p]--;
                // A waiting write response needs an accepted write behind it
                assert (wr_out[p] >= 0 && wr_out[p] <= 1
                        && (!bvalid[p] || bready[p] || wr_out[p] == 1)) else begin
                    $display("Port %0d write responses out of step, count %0d, bvalid %0b",
                             p, wr_out[p], bvalid[p]);
                    errors++;
                end
                assert (rd_out[p] >= 0 && rd_out[p] <= 2) else begin
                    $display("Port %0d has %0d read items waiting", p, rd_out[p]);
                    errors++;
                end
            end
        end
    end

    function automatic int port_base(input int p);
        return p * half_words;
    endfunction

    // Model of a strobed write, byte by byte
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic write_word(input int p, input int word, input logic [31:0] data,
                              input logic [3:0] strb);
        repeat ($urandom_range(3)) @(posedge a_clk);
        aw[p].addr   <= 12'(word * 4);
        aw[p].prot   <= 3'($urandom_range(7));
        w[p].data    <= data;
        w[p].strb    <= strb;
        awvalid[p]   <= 1'b1;
        wvalid[p]    <= 1'b1;
        do @(posedge a_clk); while (!(awready[p] && wready[p]));
        awvalid[p] <= 1'b0;
        wvalid[p]  <= 1'b0;
        bready[p]  <= ($urandom_range(2) != 0);
        forever begin
            @(posedge a_clk);
            if (bvalid[p] && bready[p]) break;
            bready[p] <= ($urandom_range(2) != 0);
        end
        check_value("bresp", axil_resp_okay, b[p].resp);
        bready[p] <= 1'b0;
        model[word] = merge_bytes(model[word], data, strb);
    endtask

    // Issues addresses and collects data in parallel, so reads can queue up
    task automatic read_words(input int p, input int n, input int base, input int span);
        logic [31:0] expect_q [$];
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    int word;
                    word = base + $urandom_range(span - 1);
                    repeat ($urandom_range(2)) @(posedge a_clk);
                    ar[p].addr <= 12'(word * 4);
                    ar[p].prot <= 3'($urandom_range(7));
                    arvalid[p] <= 1'b1;
                    do @(posedge a_clk); while (!arready[p]);
                    expect_q.push_back(model[word]);
                    arvalid[p] <= 1'b0;
                end
            end
            begin
                rready[p] <= ($urandom_range(2) != 0);
                for (int i = 0; i < n; i++) begin
                    forever begin
                        @(posedge a_clk);
                        if (rvalid[p] && rready[p]) break;
                        rready[p] <= ($urandom_range(2) != 0);
                    end
                    check_value("rdata", expect_q.pop_front(), r[p].data);
                    check_value("rresp", axil_resp_okay, r[p].resp);
                end
                rready[p] <= 1'b0;
            end
        join
    endtask

    task automatic own_half_traffic(input int p);
        for (int i = 0; i < n_txn; i++) begin
            write_word(p, port_base(p) + 64 + $urandom_range(31), $urandom, 4'hf);
        end
        read_words(p, n_txn, port_base(p) + 64, 32);
    endtask

    // Writes and reads pending together on one port, on disjoint words
    task automatic mixed_traffic(input int p);
        fork
            for (int i = 0; i < n_mixed; i++) begin
                write_word(p, port_base(p) + 128 + $urandom_range(63), $urandom,
                           4'($urandom_range(15)));
            end
            read_words(p, n_mixed, port_base(p), 128);
        join
    endtask

    task automatic end_test(input int errors_before);
        if (errors == errors_before) begin
            passes++;
            $display("Test %s: pass", test_name);
        end else begin
            fails++;
            $display("Test %s: fail, %0d errors", test_name, errors - errors_before);
        end
    endtask

    initial begin
        int mark;
        void'($urandom(32'hac5977d0));
        errors = 0;
        passes = 0;
        fails  = 0;
        cycles = 0;
        for (int p = 0; p < 2; p++) begin
            aw[p] = '0;
            ar[p] = '0;
            w[p]  = '0;
            awvalid[p] = 1'b0;
            wvalid[p]  = 1'b0;
            arvalid[p] = 1'b0;
            bready[p]  = 1'b0;
            rready[p]  = 1'b0;
            rd_out[p]  = 0;
            wr_out[p]  = 0;
        end
        for (int i = 0; i < ram_depth; i++) model[i] = '0;
        a_rst = 1'b1;
        repeat (2) @(posedge a_clk);
        a_rst <= 1'b0;
        @(posedge a_clk);

        test_name = "reset_state";
        mark = errors;
        for (int p = 0; p < 2; p++) begin
            check_value("awready", 0, awready[p]);
            check_value("wready", 0, wready[p]);
            check_value("arready", 0, arready[p]);
            check_value("bvalid", 0, bvalid[p]);
            check_value("rvalid", 0, rvalid[p]);
        end
        fork
            read_words(0, 8, 0, ram_depth);
            read_words(1, 8, 0, ram_depth);
        join
        end_test(mark);

        test_name = "full_writes";
        mark = errors;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < n_txn; i++) begin
                write_word(p, port_base(p) + $urandom_range(15), $urandom, 4'hf);
            end
            read_words(p, n_txn, port_base(p), 16);
        end
        end_test(mark);

        test_name = "partial_strobes";
        mark = errors;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < n_txn; i++) begin
                write_word(p, port_base(p) + 16 + $urandom_range(7), $urandom,
                           4'($urandom_range(15)));
            end
            read_words(p, n_txn, port_base(p) + 16, 8);
        end
        end_test(mark);

        test_name = "two_ports";
        mark = errors;
        fork
            own_half_traffic(0);
            own_half_traffic(1);
        join
        // Both ports idle, so each may read the other half
        fork
            read_words(0, n_txn, port_base(1), 96);
            read_words(1, n_txn, port_base(0), 96);
        join
        end_test(mark);

        test_name = "mixed_stalls";
        mark = errors;
        fork
            mixed_traffic(0);
            mixed_traffic(1);
        join
        repeat (2) @(posedge a_clk);
        // Every response was taken, so none may still be offered
        for (int p = 0; p < 2; p++) begin
            check_value("bvalid after idle", 0, bvalid[p]);
            check_value("rvalid after idle", 0, rvalid[p]);
        end
        end_test(mark);

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d", passes, fails, errors);
        if (errors == 0 && fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/axil_ram_pkg.sv
hdl/dp_byte_ram.sv
hdl/axil_port_ctrl.sv
hdl/axil_rdata_pipe.sv
hdl/axil_dp_ram.sv
test/tb_axil_dp_ram.sv

/* Bender.yml */
package:
  name: axil_dp_ram

sources:
  - hdl/axil_ram_pkg.sv
  - hdl/dp_byte_ram.sv
  - hdl/axil_port_ctrl.sv
  - hdl/axil_rdata_pipe.sv
  - hdl/axil_dp_ram.sv
  - target: test
    files:
      - test/tb_axil_dp_ram.sv
